/* cpuPkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpuPkg;

    typedef logic [`WORD_SIZE-1:0]         wordT;
    typedef logic [$clog2(`NUM_REGS)-1:0]  regIdxT;

    typedef enum logic [3:0] {
        opBne = 4'd0,
        opBeq = 4'd1,
        opAdi = 4'd4,
        opLhi = 4'd6,
        opLwd = 4'd7,
        opSwd = 4'd8,
        opJmp = 4'd9,
        opAlu = 4'd15   // R-type, func field picks the operation
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluLhi,     // result is the placed immediate
        aluPassA
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrcB;     // operand B from immediate
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  isWwd;
        logic  isHalt;
        logic  isDone;      // counts as a retired instruction
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT   ctrl;
        wordT   opA;
        wordT   opB;
        wordT   imm;
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;
    } idExT;

    typedef struct packed {
        ctrlT   ctrl;
        wordT   aluResult;  // also the data address
        wordT   storeData;
        wordT   wwdData;
        regIdxT rd;
    } exMemT;

    typedef struct packed {
        ctrlT   ctrl;
        wordT   memData;
        wordT   aluResult;
        wordT   wwdData;
        regIdxT rd;
    } memWbT;

    // operand source, lowest priority first
    typedef enum logic [1:0] {
        fwdReg,
        fwdWb,
        fwdMem,
        fwdEx
    } fwdSelE;

endpackage

`default_nettype wire

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define WORD_SIZE 16

// architectural registers, $0..$3
`define NUM_REGS 4

// first fetch address out of reset
`define RESET_PC 0

`endif

/* datapath.f */
+incdir+.
cpuPkg.sv
pipeReg.sv
regFile.sv
decodeUnit.sv
hazardUnit.sv
execUnit.sv
datapath.sv
tbMemory.sv
datapathTb.sv

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module datapath import cpuPkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    output logic      readM1,
    output wordT      address1,
    input  wire wordT data1,
    output logic      readM2,
    output logic      writeM2,
    output wordT      address2,
    input  wire wordT dataIn,
    output wordT      dataOut,
    output wordT      numInst,
    output wordT      outputPort,
    output logic      isHalted
);

    wordT   pc;
    wordT   nextPc;
    ifIdT   ifIdD, ifIdQ;
    idExT   idExD, idExQ;
    exMemT  exMemD, exMemQ;
    memWbT  memWbD, memWbQ;
    ctrlT   idCtrl;
    wordT   idImm;
    regIdxT idRs, idRt, idRd;
    logic   isBranch, isJump, branchNe, idUsesRt;
    wordT   rData1, rData2, idOpA, idOpB;
    logic   stall, flush, branchTaken;
    logic   haltPending, haltFetch;
    fwdSelE fwdIdA, fwdIdB, fwdExA, fwdExB;
    wordT   exOpA, exOpB, exResult;
    wordT   memFwd, wbData;

    function automatic wordT fwdPick(fwdSelE sel, wordT regVal, wordT wbVal,
                                     wordT memVal, wordT exVal);
        case (sel)
            fwdEx:   return exVal;
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign readM1   = !isHalted;
    assign address1 = pc;
    assign ifIdD    = '{pc: pc, instr: data1};

    // once HLT is decoded nothing younger may enter
    assign haltFetch = haltPending || idCtrl.isHalt;

    always_comb begin
        if (isJump) begin
            nextPc = {ifIdQ.pc[`WORD_SIZE-1:`WORD_SIZE-4], ifIdQ.instr[11:0]};
        end else if (branchTaken) begin
            nextPc = ifIdQ.pc + wordT'(1) + idImm;
        end else begin
            nextPc = pc + wordT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= wordT'(`RESET_PC);
        end else if (!stall && !haltFetch) begin
            pc <= nextPc;
        end
    end

    pipeReg #(.payloadT(ifIdT)) ifId (
        .clk(clk), .rst(rst),
        .stall(stall), .bubble(flush),
        .d(ifIdD), .q(ifIdQ)
    );

    // decode
    decodeUnit decoder (
        .instr(ifIdQ.instr), .ctrl(idCtrl), .imm(idImm),
        .rs(idRs), .rt(idRt), .rd(idRd),
        .isBranch(isBranch), .isJump(isJump), .branchNe(branchNe)
    );

    // R-type ALU ops, stores and branches read rt
    assign idUsesRt = isBranch || idCtrl.memWrite || (idCtrl.regWrite && !idCtrl.aluSrcB);

    regFile regs (
        .clk(clk), .rst(rst), .rs(idRs), .rt(idRt),
        .wAddr(memWbQ.rd), .wData(wbData), .wEn(memWbQ.ctrl.regWrite),
        .rData1(rData1), .rData2(rData2)
    );

    hazardUnit hazard (
        .idRs(idRs), .idRt(idRt), .idUsesRt(idUsesRt), .isBranch(isBranch),
        .exCtrl(idExQ.ctrl), .exRd(idExQ.rd),
        .memCtrl(exMemQ.ctrl), .memRd(exMemQ.rd),
        .exRs(idExQ.rs), .exRt(idExQ.rt),
        .stall(stall),
        .fwdIdA(fwdIdA), .fwdIdB(fwdIdB), .fwdExA(fwdExA), .fwdExB(fwdExB)
    );

    assign idOpA = fwdPick(fwdIdA, rData1, wbData, memFwd, exResult);
    assign idOpB = fwdPick(fwdIdB, rData2, wbData, memFwd, exResult);

    assign branchTaken = isBranch && ((idOpA == idOpB) ^ branchNe);
    assign flush       = !stall && (branchTaken || isJump || haltFetch);

    assign idExD = '{ctrl: idCtrl, opA: idOpA, opB: idOpB, imm: idImm,
                     rs: idRs, rt: idRt, rd: idRd};

    pipeReg #(.payloadT(idExT)) idEx (
        .clk(clk), .rst(rst),
        .stall(1'b0), .bubble(stall),
        .d(idExD), .q(idExQ)
    );

    // execute
    assign exOpA = (fwdExA == fwdMem) ? memFwd : idExQ.opA;
    assign exOpB = (fwdExB == fwdMem) ? memFwd : idExQ.opB;

    execUnit alu (
        .ctrl(idExQ.ctrl), .opA(exOpA), .opB(exOpB),
        .imm(idExQ.imm), .result(exResult)
    );

    assign exMemD = '{ctrl: idExQ.ctrl, aluResult: exResult, storeData: exOpB,
                      wwdData: exOpA, rd: idExQ.rd};

    pipeReg #(.payloadT(exMemT)) exMem (
        .clk(clk), .rst(rst),
        .stall(1'b0), .bubble(1'b0),
        .d(exMemD), .q(exMemQ)
    );

    // memory
    assign readM2   = exMemQ.ctrl.memRead;
    assign writeM2  = exMemQ.ctrl.memWrite;
    assign address2 = (readM2 || writeM2) ? exMemQ.aluResult : '0;
    assign dataOut  = exMemQ.storeData;
    assign memFwd   = exMemQ.ctrl.memRead ? dataIn : exMemQ.aluResult;

    assign memWbD = '{ctrl: exMemQ.ctrl, memData: dataIn, aluResult: exMemQ.aluResult,
                      wwdData: exMemQ.wwdData, rd: exMemQ.rd};

    pipeReg #(.payloadT(memWbT)) memWb (
        .clk(clk), .rst(rst),
        .stall(1'b0), .bubble(1'b0),
        .d(memWbD), .q(memWbQ)
    );

    // write-back
    assign wbData = memWbQ.ctrl.memToReg ? memWbQ.memData : memWbQ.aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            numInst     <= '0;
            outputPort  <= '0;
            isHalted    <= 1'b0;
            haltPending <= 1'b0;
        end else begin
            if (memWbQ.ctrl.isDone) begin
                numInst <= numInst + wordT'(1);
            end
            if (memWbQ.ctrl.isWwd) begin
                outputPort <= memWbQ.wwdData;
            end
            if (memWbQ.ctrl.isHalt) begin
                isHalted <= 1'b1;   // sticky until reset
            end
            if (idCtrl.isHalt && !stall) begin
                haltPending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* datapathTb.sv */
`timescale 1ns/1ps
`default_nettype none

module datapathTb;

    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opAlu = 4'd15;
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    logic        clk;
    logic        rst;
    logic        readM1;
    logic        readM2;
    logic        writeM2;
    logic        isHalted;
    logic [15:0] address1;
    logic [15:0] data1;
    logic [15:0] address2;
    logic [15:0] dataIn;
    logic [15:0] dataOut;
    logic [15:0] numInst;
    logic [15:0] outputPort;

    logic [15:0] prog [256];
    int          progLen;
    logic [15:0] modelRegs [4];
    logic [15:0] modelMem [256];
    logic [15:0] expWwd [$];
    logic [15:0] expStoreAddr [$];
    logic [15:0] expStoreData [$];
    int          expCount;
    int          errors;
    int          wwdIdx;
    int          storeIdx;
    logic        wwdPending;
    logic        haltSeen;

    datapath u_dut (
        .clk(clk), .rst(rst),
        .readM1(readM1), .address1(address1), .data1(data1),
        .readM2(readM2), .writeM2(writeM2), .address2(address2),
        .dataIn(dataIn), .dataOut(dataOut),
        .numInst(numInst), .outputPort(outputPort), .isHalted(isHalted)
    );

    tbMemory mem (
        .clk(clk),
        .instrRead(readM1), .instrAddr(address1), .instrData(data1),
        .dataRead(readM2), .dataWrite(writeM2), .dataAddr(address2),
        .writeData(dataOut), .readData(dataIn)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [15:0] expVal,
                                  input logic [15:0] gotVal);
        errors++;
        $display("FAIL t=%0t %s expected %h actual %h", $time, name, expVal, gotVal);
    endtask

    function automatic logic [15:0] sext8(logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] encR(logic [1:0] rs, logic [1:0] rt, logic [1:0] rd,
                                         logic [5:0] fn);
        return {opAlu, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encI(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
                                         logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [15:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [7:0] immA;
        logic [7:0] immB;
        logic [7:0] immC;
        immA = 8'($urandom);
        immB = 8'($urandom);
        immC = 8'($urandom);
        for (int i = 0; i < 256; i++) begin
            prog[i] = '0;
        end
        progLen = 0;
        // dependent ALU chain
        emit(encI(opAdi, 2'd0, 2'd1, immA));
        emit(encI(opAdi, 2'd1, 2'd2, immB));
        emit(encR(2'd1, 2'd2, 2'd3, fnAdd));
        emit(encR(2'd3, 2'd2, 2'd1, fnSub));
        emit(encR(2'd1, 2'd3, 2'd2, fnAnd));
        emit(encR(2'd2, 2'd1, 2'd3, fnOrr));
        emit(encR(2'd3, 2'd0, 2'd0, fnWwd));
        emit(encR(2'd1, 2'd0, 2'd0, fnWwd));
        emit(encI(opLhi, 2'd0, 2'd0, immC));
        emit(encR(2'd0, 2'd3, 2'd2, fnAdd));
        emit(encR(2'd2, 2'd0, 2'd0, fnWwd));
        // store then load back, base 16
        emit(encR(2'd1, 2'd1, 2'd1, fnSub));
        emit(encI(opAdi, 2'd1, 2'd1, 8'h10));
        emit(encI(opSwd, 2'd1, 2'd2, 8'd3));
        emit(encI(opLwd, 2'd1, 2'd3, 8'd3));
        emit(encR(2'd3, 2'd3, 2'd0, fnAdd));   // load-use
        emit(encR(2'd0, 2'd0, 2'd0, fnWwd));
        emit(encR(2'd3, 2'd0, 2'd0, fnWwd));
        // branches, each skipped slot holds a WWD
        emit(encI(opBeq, 2'd3, 2'd2, 8'd1));   // taken
        emit(encR(2'd1, 2'd0, 2'd0, fnWwd));
        emit(encI(opBne, 2'd3, 2'd2, 8'd1));   // not taken
        emit(encR(2'd0, 2'd0, 2'd0, fnWwd));
        emit(encI(opLwd, 2'd1, 2'd0, 8'd3));
        emit(encI(opBne, 2'd0, 2'd2, 8'd1));   // right after a load
        emit(encI(opAdi, 2'd0, 2'd0, 8'd1));
        emit(encI(opBne, 2'd0, 2'd2, 8'd1));   // taken
        emit(encR(2'd2, 2'd0, 2'd0, fnWwd));
        emit(encI(opLwd, 2'd1, 2'd3, 8'd3));
        emit(encI(opBeq, 2'd3, 2'd0, 8'd1));   // not taken
        emit(encR(2'd0, 2'd0, 2'd0, fnWwd));
        emit({opJmp, 12'd32});
        emit(encR(2'd1, 2'd0, 2'd0, fnWwd));
        emit(encI(opSwd, 2'd1, 2'd0, 8'd4));
        emit(encR(2'd3, 2'd0, 2'd0, fnWwd));
        emit(encR(2'd0, 2'd0, 2'd0, fnHlt));
        emit(encI(opSwd, 2'd1, 2'd3, 8'd5));   // only ever fetched behind HLT
    endtask

    // architectural reference, one instruction per step
    task automatic runModel();
        logic [15:0] pc;
        logic [15:0] curPc;
        logic [15:0] instr;
        logic [15:0] addr;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [1:0]  rd;
        logic        done;
        int          steps;
        pc = 16'd0;
        done = 1'b0;
        steps = 0;
        expCount = 0;
        for (int i = 0; i < 4; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = '0;
        end
        while (!done && steps < 1000) begin
            curPc = pc;
            instr = prog[pc[7:0]];
            rs = instr[11:10];
            rt = instr[9:8];
            rd = instr[7:6];
            addr = modelRegs[rs] + sext8(instr[7:0]);
            pc = pc + 16'd1;
            expCount++;
            steps++;
            case (instr[15:12])
                opAlu: begin
                    case (instr[5:0])
                        fnAdd:   modelRegs[rd] = modelRegs[rs] + modelRegs[rt];
                        fnSub:   modelRegs[rd] = modelRegs[rs] - modelRegs[rt];
                        fnAnd:   modelRegs[rd] = modelRegs[rs] & modelRegs[rt];
                        fnOrr:   modelRegs[rd] = modelRegs[rs] | modelRegs[rt];
                        fnWwd:   expWwd.push_back(modelRegs[rs]);
                        fnHlt:   done = 1'b1;
                        default: ;
                    endcase
                end
                opAdi: modelRegs[rt] = addr;
                opLhi: modelRegs[rt] = {instr[7:0], 8'h00};
                opLwd: modelRegs[rt] = modelMem[addr[7:0]];
                opSwd: begin
                    modelMem[addr[7:0]] = modelRegs[rt];
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(modelRegs[rt]);
                end
                opBne: begin
                    if (modelRegs[rs] != modelRegs[rt]) begin
                        pc = pc + sext8(instr[7:0]);
                    end
                end
                opBeq: begin
                    if (modelRegs[rs] == modelRegs[rt]) begin
                        pc = pc + sext8(instr[7:0]);
                    end
                end
                opJmp:   pc = {curPc[15:12], instr[11:0]};
                default: ;
            endcase
        end
        if (!done) begin
            errors++;
            $display("reference model never reached HLT");
        end
    endtask

    task automatic checkResetValues();
        assert (readM1 == 1'b1) else reportMismatch("readM1", 16'd1, 16'(readM1));
        assert (address1 == 16'd0) else reportMismatch("address1", 16'd0, address1);
        assert (readM2 == 1'b0) else reportMismatch("readM2", 16'd0, 16'(readM2));
        assert (writeM2 == 1'b0) else reportMismatch("writeM2", 16'd0, 16'(writeM2));
        assert (isHalted == 1'b0) else reportMismatch("isHalted", 16'd0, 16'(isHalted));
        assert (numInst == 16'd0) else reportMismatch("numInst", 16'd0, numInst);
        assert (outputPort == 16'd0) else reportMismatch("outputPort", 16'd0, outputPort);
    endtask

    // outputs are sampled half a cycle away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            if (wwdPending) begin   // outputPort loaded at the last edge
                if (wwdIdx < expWwd.size()) begin
                    assert (outputPort == expWwd[wwdIdx])
                        else reportMismatch("outputPort", expWwd[wwdIdx], outputPort);
                end else begin
                    errors++;
                    $display("more WWD results than the program produces at t=%0t", $time);
                end
                wwdIdx++;
            end
            wwdPending = u_dut.memWbQ.ctrl.isWwd;
            if (writeM2) begin
                if (storeIdx < expStoreAddr.size()) begin
                    assert (address2 == expStoreAddr[storeIdx])
                        else reportMismatch("address2", expStoreAddr[storeIdx], address2);
                    assert (dataOut == expStoreData[storeIdx])
                        else reportMismatch("dataOut", expStoreData[storeIdx], dataOut);
                end else begin
                    errors++;
                    $display("unexpected store to data memory at t=%0t", $time);
                end
                storeIdx++;
            end
            if (haltSeen) begin
                assert (isHalted) else begin
                    errors++;
                    $display("isHalted dropped after the core halted at t=%0t", $time);
                end
            end
            assert (!isHalted || !readM1) else reportMismatch("readM1", 16'd0, 16'(readM1));
            if (isHalted) begin
                haltSeen = 1'b1;
            end
        end
    end

    noStoreAfterHalt: assert property (@(posedge clk) disable iff (rst) isHalted |-> !writeM2)
        else begin
            errors++;
            $display("data memory written while halted at t=%0t", $time);
        end

    initial begin
        int waitCycles;
        rst <= 1'b1;
        errors = 0;
        wwdIdx = 0;
        storeIdx = 0;
        wwdPending = 1'b0;
        haltSeen = 1'b0;
        void'($urandom(59549));
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            mem.rom[i] = prog[i];
        end
        runModel();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkResetValues();

        waitCycles = 0;
        while (!isHalted && waitCycles < 2000) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!isHalted) begin
            errors++;
            $display("timeout, isHalted not seen within 2000 cycles");
        end else begin
            // stay around to see isHalted hold and no stray store
            waitCycles = 0;
            while (waitCycles < 20) begin
                @(negedge clk);
                waitCycles++;
            end
            assert (numInst == 16'(expCount))
                else reportMismatch("numInst", 16'(expCount), numInst);
            if (wwdIdx != expWwd.size()) begin
                errors++;
                $display("saw %0d WWD results, program produces %0d", wwdIdx, expWwd.size());
            end
            if (storeIdx != expStoreAddr.size()) begin
                errors++;
                $display("saw %0d stores, program performs %0d", storeIdx,
                         expStoreAddr.size());
            end
        end

        $display("summary: %0d errors, %0d/%0d WWD values, %0d/%0d stores, numInst %0d",
                 errors, wwdIdx, expWwd.size(), storeIdx, expStoreAddr.size(), numInst);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnit import cpuPkg::*; (
    input  wire wordT instr,
    output ctrlT      ctrl,
    output wordT      imm,
    output regIdxT    rs,
    output regIdxT    rt,
    output regIdxT    rd,
    output logic      isBranch,
    output logic      isJump,
    output logic      branchNe
);

    opcodeE opcode;
    funcE   func;
    logic   isRType;
    logic   isBubble;
    wordT   immSext;
    wordT   immHigh;

    assign opcode  = opcodeE'(instr[15:12]);
    assign func    = funcE'(instr[5:0]);
    assign isRType = (opcode == opAlu);

    // a flushed ifId slot is all zeros, never treat it as BNE
    assign isBubble = (instr == '0);

    assign rs = instr[11:10];
    assign rt = instr[9:8];
    assign rd = isRType ? instr[7:6] : instr[9:8];   // ADI, LHI, LWD write rt

    assign immSext = wordT'(signed'(instr[7:0]));
    assign immHigh = wordT'(instr[7:0]) << 8;        // LHI fills the upper byte

    always_comb begin
        ctrl     = '0;
        imm      = immSext;
        isBranch = 1'b0;
        isJump   = 1'b0;
        branchNe = 1'b0;
        if (!isBubble) begin
            ctrl.isDone = 1'b1;
            case (opcode)
                opAlu: begin
                    case (func)
                        fnAdd: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.aluOp    = aluAdd;
                        end
                        fnSub: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.aluOp    = aluSub;
                        end
                        fnAnd: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.aluOp    = aluAnd;
                        end
                        fnOrr: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.aluOp    = aluOr;
                        end
                        fnWwd: begin
                            ctrl.isWwd = 1'b1;
                            ctrl.aluOp = aluPassA;
                        end
                        fnHlt:   ctrl.isHalt = 1'b1;
                        default: ctrl.isDone = 1'b0;   // unsupported function
                    endcase
                end
                opAdi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                end
                opLhi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.aluOp    = aluLhi;
                    imm           = immHigh;
                end
                opLwd: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                end
                opSwd: begin
                    ctrl.aluSrcB  = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
                opBne, opBeq: begin
                    isBranch = 1'b1;
                    branchNe = (opcode == opBne);
                end
                opJmp:   isJump = 1'b1;
                default: ctrl.isDone = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import cpuPkg::*; (
    input  wire ctrlT ctrl,
    input  wire wordT opA,
    input  wire wordT opB,
    input  wire wordT imm,
    output wordT      result
);

    wordT aluB;

    assign aluB = ctrl.aluSrcB ? imm : opB;   // ADI, LWD, SWD take the immediate

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  result = opA + aluB;
            aluSub:  result = opA - aluB;
            aluAnd:  result = opA & aluB;
            aluOr:   result = opA | aluB;
            aluLhi:  result = imm;            // already shifted in decode
            default: result = opA;            // WWD passes rs through
        endcase
    end

endmodule

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
    input  wire regIdxT idRs,
    input  wire regIdxT idRt,
    input  wire logic   idUsesRt,
    input  wire logic   isBranch,
    input  wire ctrlT   exCtrl,
    input  wire regIdxT exRd,
    input  wire ctrlT   memCtrl,
    input  wire regIdxT memRd,
    input  wire regIdxT exRs,
    input  wire regIdxT exRt,
    output logic        stall,
    output fwdSelE      fwdIdA,
    output fwdSelE      fwdIdB,
    output fwdSelE      fwdExA,
    output fwdSelE      fwdExB
);

    logic exHitA;
    logic exHitB;
    logic memHitA;
    logic memHitB;

    // youngest producer first
    function automatic fwdSelE fwdPrio(logic exHit, logic memHit);
        if (exHit) begin
            return fwdEx;
        end else if (memHit) begin
            return fwdMem;
        end
        return fwdReg;
    endfunction

    assign exHitA  = exCtrl.regWrite && (exRd == idRs);
    assign exHitB  = exCtrl.regWrite && idUsesRt && (exRd == idRt);
    assign memHitA = memCtrl.regWrite && (memRd == idRs);
    assign memHitB = memCtrl.regWrite && idUsesRt && (memRd == idRt);

    // load data is not there yet; a branch also waits out the memory stage
    assign stall = (exCtrl.memRead && (exHitA || exHitB))
                || (isBranch && memCtrl.memRead && (memHitA || memHitB));

    assign fwdIdA = fwdPrio(exHitA, memHitA);
    assign fwdIdB = fwdPrio(exHitB, memHitB);

    // execute only looks one stage ahead
    assign fwdExA = fwdPrio(1'b0, memCtrl.regWrite && (memRd == exRs));
    assign fwdExB = fwdPrio(1'b0, memCtrl.regWrite && (memRd == exRt));

endmodule

`default_nettype wire

/* pipeReg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    stall,     // keep current contents
    input  wire logic    bubble,    // load all zeros, i.e. a nop
    input  wire payloadT d,
    output payloadT      q
);

    // bubble wins over stall so a flush is never lost
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module regFile import cpuPkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire regIdxT rs,
    input  wire regIdxT rt,
    input  wire regIdxT wAddr,
    input  wire wordT   wData,
    input  wire logic   wEn,
    output wordT        rData1,
    output wordT        rData2
);

    wordT regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn) begin
            regs[wAddr] <= wData;
        end
    end

    // write-back value shows through in the same cycle
    assign rData1 = (wEn && wAddr == rs) ? wData : regs[rs];
    assign rData2 = (wEn && wAddr == rt) ? wData : regs[rt];

endmodule

`default_nettype wire

/* runSim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module datapathTb -f datapath.f -o simDatapath

./obj_dir/simDatapath | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tbMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMemory (
    input  wire logic        clk,
    input  wire logic        instrRead,
    input  wire logic [15:0] instrAddr,
    output logic [15:0]      instrData,
    input  wire logic        dataRead,
    input  wire logic        dataWrite,
    input  wire logic [15:0] dataAddr,
    input  wire logic [15:0] writeData,
    output logic [15:0]      readData
);

    // 256 words each, upper address bits ignored
    logic [15:0] rom [256];   // loaded by the testbench before reset ends
    logic [15:0] ram [256];

    // instruction port, combinational read
    assign instrData = instrRead ? rom[instrAddr[7:0]] : '0;

    // data port reads in the same cycle
    assign readData = dataRead ? ram[dataAddr[7:0]] : '0;

    always @(posedge clk) begin
        if (dataWrite) begin
            ram[dataAddr[7:0]] <= writeData;   // store lands at the edge
        end
    end

endmodule

`default_nettype wire
